// File: verilog.f
hw/pov_pkg.sv
hw/scan_timer.sv
hw/scan_fsm.sv
hw/column_loader.sv
hw/bit_slicer.sv
hw/pov_framebuffer.sv
dv/image_ram.sv
dv/pov_checker.sv
dv/tb_pov_framebuffer.sv

// File: dv/tb_pov_framebuffer.sv
module tb_pov_framebuffer;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAM_ADDR_WIDTH  = 32;
    localparam int RAM_BASE        = 64;
    localparam int POKER_MODE      = 9;
    localparam int BLANKING_CYCLES = 8;
    localparam int COLUMN_CYCLES   = BLANKING_CYCLES + 48 * POKER_MODE;
    localparam int SLICE_CYCLES    = 8 * COLUMN_CYCLES;
    // From the sync cycle (blank cycle 1 of column 0) to blank cycle 2 of column 7
    localparam int TO_COL7_BLANK   = 7 * COLUMN_CYCLES + 1;
    localparam int SYNC_TIMEOUT    = SLICE_CYCLES + 4 * COLUMN_CYCLES;
    localparam int NUM_ENTRIES     = 4;

    // Encoder position, the image start it must select, and slices to watch
    typedef struct packed {
        logic [7:0]  position;
        logic [31:0] image_start;
        logic [3:0]  slices;
    } entry_t;

    entry_t entries [NUM_ENTRIES];

    logic                      clk_33 = 1'b0;
    logic                      nrst;
    logic [7:0]                enc_position;
    logic                      enc_sync;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    logic [15:0]               ram_data;
    logic [29:0]               data;
    logic                      sync;
    logic [31:0]               pattern_seed;
    logic [31:0]               expected_start;
    logic                      test_end;
    int                        tests_run;
    int                        tests_failed;
    int                        error_count;

    pov_framebuffer #(
        .RAM_ADDR_WIDTH  (RAM_ADDR_WIDTH),
        .RAM_BASE        (RAM_BASE),
        .POKER_MODE      (POKER_MODE),
        .BLANKING_CYCLES (BLANKING_CYCLES)
    ) i_dut (
        .clk_33       (clk_33),
        .nrst         (nrst),
        .enc_position (enc_position),
        .enc_sync     (enc_sync),
        .ram_addr     (ram_addr),
        .ram_data     (ram_data),
        .data         (data),
        .sync         (sync)
    );

    image_ram #(
        .ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) i_ram (
        .seed (pattern_seed),
        .addr (ram_addr),
        .data (ram_data)
    );

    pov_checker #(
        .RAM_BASE        (RAM_BASE),
        .POKER_MODE      (POKER_MODE),
        .BLANKING_CYCLES (BLANKING_CYCLES)
    ) i_checker (
        .clk_33         (clk_33),
        .nrst           (nrst),
        .enc_sync       (enc_sync),
        .enc_position   (enc_position),
        .expected_start (expected_start),
        .test_end       (test_end),
        .seed           (pattern_seed),
        .data           (data),
        .sync           (sync),
        .tests_run      (tests_run),
        .tests_failed   (tests_failed),
        .error_count    (error_count)
    );

    initial begin
        forever #2 clk_33 = ~clk_33;
    end

    // Every step lands 1 ns after a rising edge
    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge clk_33);
            #1;
        end
    endtask

    task automatic wait_for_sync();
        int n;
        n = 0;
        do begin
            @(posedge clk_33);
            #1;
            n++;
        end while (sync !== 1'b1 && n < SYNC_TIMEOUT);
        if (sync !== 1'b1) begin
            $display("Timeout: the DUT gave no sync pulse within %0d clock cycles", SYNC_TIMEOUT);
            $display(">>> FAIL");
            $finish;
        end
    endtask

    initial begin
        nrst           = 1'b0;
        enc_position   = '0;
        enc_sync       = 1'b0;
        test_end       = 1'b0;
        expected_start = 32'(RAM_BASE);
        pattern_seed   = $urandom(32'ha407);
        // Start address is RAM_BASE + 1920 x position and 255 reaches the top of the range
        entries[0] = '{8'd0, 32'd64, 4'd2};
        entries[1] = '{8'd1, 32'd1984, 4'd1};
        entries[2] = '{8'd255, 32'd489664, 4'd1};
        entries[3] = '{8'd37, 32'd71104, 4'd1};
        run_cycles(4);
        nrst = 1'b1;
        wait_for_sync();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_cycles(TO_COL7_BLANK);
            // The previous test closes in the cycle that switches to the new image
            enc_position   = entries[i].position;
            expected_start = entries[i].image_start;
            enc_sync       = 1'b1;
            test_end       = 1'b1;
            run_cycles(1);
            enc_sync = 1'b0;
            test_end = 1'b0;
            // The first sync opens the new image and one more closes each watched slice
            repeat (entries[i].slices + 1) begin
                wait_for_sync();
            end
        end
        test_end = 1'b1;
        run_cycles(1);
        test_end = 1'b0;
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && tests_run == NUM_ENTRIES + 1) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: dv/pov_checker.sv
module pov_checker #(
    parameter int RAM_BASE        = 0,
    parameter int POKER_MODE      = 9,
    parameter int BLANKING_CYCLES = 72
) (
    input  logic        clk_33,
    input  logic        nrst,
    input  logic        enc_sync,
    input  logic [7:0]  enc_position,
    input  logic [31:0] expected_start,
    input  logic        test_end,
    input  logic [31:0] seed,
    input  logic [29:0] data,
    input  logic        sync,
    output int          tests_run,
    output int          tests_failed,
    output int          error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    // A column is the blank gap plus 48 shift slots (3 colours x 16 LEDs) per bit slot
    localparam int COLUMN_CYCLES = BLANKING_CYCLES + 48 * POKER_MODE;
    localparam int SLICE_CYCLES  = 8 * COLUMN_CYCLES;
    localparam int MAX_PRINTS    = 20;

    int unsigned cyc;
    logic [31:0] load_start;
    logic [31:0] disp_start;
    int          load_col;
    int          disp_col;
    int          cur_pos;
    int          test_errors;
    int          test_words;
    int          test_cycles;
    int          prints;

    // Buffer index of driver d for one LED with the pairs five to a row of 80 words
    function automatic int buffer_index(input int d, input int led);
        int pair;
        pair = d / 2;
        return (pair % 5) + 80 * (pair / 5) + 5 * led;
    endfunction

    // True when the scan step at cycle t is a shift slot that carries a field bit
    function automatic bit data_slot(input int unsigned t);
        int q;
        int s;
        int slot;
        q = t % COLUMN_CYCLES;
        if (q < BLANKING_CYCLES) begin
            return 1'b0;
        end
        s = q - BLANKING_CYCLES;
        slot = POKER_MODE - 1 - s / 48;
        return (slot > 3) || ((s % 3 == 1) && (slot == 3));
    endfunction

    // Driver word for the data slot at cycle t, built from the displayed column
    function automatic logic [29:0] expected_word(input int unsigned t);
        logic [29:0] w;
        logic [15:0] pix;
        int s;
        int colour;
        int led;
        int bit_pos;
        s = t % COLUMN_CYCLES - BLANKING_CYCLES;
        colour = s % 3;
        led = (s / 3) % 16;
        // Red sits in bits 15..11, green in 10..5 and blue in 4..0
        if (colour == 1) begin
            bit_pos = 5 + (POKER_MODE - 1 - s / 48) - 3;
        end else begin
            bit_pos = (colour == 0 ? 11 : 0) + (POKER_MODE - 1 - s / 48) - 4;
        end
        for (int d = 0; d < 30; d++) begin
            pix = tb_pov_framebuffer.i_ram.pattern_word(seed,
                disp_start + disp_col + 8 * buffer_index(d, led));
            w[d] = pix[bit_pos];
        end
        return w;
    endfunction

    task automatic compare_value(input logic [29:0] got, input logic [29:0] want,
                                 input string what);
        if (got !== want) begin
            error_count++;
            test_errors++;
            if (prints < MAX_PRINTS) begin
                $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, want);
                prints++;
            end
        end
    endtask

    task automatic report_test();
        bit ok;
        string label;
        // The startup window has no image to compare but every later one needs pixel words
        ok = (test_errors == 0) && (test_cycles > 0) && (tests_run == 0 || test_words > 0);
        label = (cur_pos < 0) ? "reset and startup" : $sformatf("position %0d", cur_pos);
        $display("Test %0d %s: %0d cycles, %0d pixel words, %0d errors, %s", tests_run,
                 label, test_cycles, test_words, test_errors, ok ? "passed" : "failed");
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        test_errors = 0;
        test_words  = 0;
        test_cycles = 0;
    endtask

    initial begin
        tests_run    = 0;
        tests_failed = 0;
        error_count  = 0;
        test_errors  = 0;
        test_words   = 0;
        test_cycles  = 0;
        prints       = 0;
        cur_pos      = -1;
        cyc          = 0;
        load_start   = 32'(RAM_BASE);
        load_col     = 0;
    end

    // Outputs change on the rising edge, so they are read on the falling edge
    always @(negedge clk_33) begin
        if (!nrst) begin
            compare_value(data, '0, "data in reset");
            compare_value({29'b0, sync}, '0, "sync in reset");
            cyc        = 0;
            load_start = 32'(RAM_BASE);
            load_col   = 0;
        end else begin
            // Sync falls in the second blank cycle of column 0 of every slice
            compare_value({29'b0, sync}, {29'b0, (cyc % SLICE_CYCLES) == 1}, "sync");
            // Data shows the scan step of the previous cycle
            if (cyc == 0 || !data_slot(cyc - 1)) begin
                compare_value(data, '0, "data in a blank or padding slot");
            end else if (cyc - 1 >= SLICE_CYCLES) begin
                compare_value(data, expected_word(cyc - 1), "data");
                test_words++;
            end
            for (int p = 0; p < 15; p++) begin
                compare_value({29'b0, data[2*p+1]}, {29'b0, data[2*p]},
                              $sformatf("driver %0d against driver %0d", 2*p+1, 2*p));
            end
            // Each new column period shows the column loaded in the period before
            if (cyc != 0 && cyc % COLUMN_CYCLES == 0) begin
                disp_start = load_start;
                disp_col   = load_col;
                load_col   = (load_col + 1) % 8;
            end
            test_cycles++;
            cyc++;
        end
        if (test_end === 1'b1) begin
            report_test();
        end
        // A new image is loaded from column 0 and reaches the display one column later
        if (enc_sync === 1'b1) begin
            load_start = expected_start;
            load_col   = 0;
            cur_pos    = enc_position;
        end
    end

endmodule

// File: dv/image_ram.sv
module image_ram #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic [31:0]           seed,
    input  logic [ADDR_WIDTH-1:0] addr,
    output logic [15:0]           data
);
    timeunit 1ns;
    timeprecision 100ps;

    // Every word is a hash of its full address, so images and columns all differ
    // The seed moves the whole pattern without storing any memory array
    function automatic logic [15:0] pattern_word(
        input logic [31:0] key,
        input logic [31:0] word_addr
    );
        logic [31:0] h;
        // Multiplying by an odd constant keeps distinct addresses distinct
        h = word_addr * 32'h9e37_79b1;
        h = h ^ key;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        // Fold both halves so the upper address bits reach every data bit
        return h[31:16] ^ h[15:0];
    endfunction

    // Read is asynchronous and the word follows the address in the same cycle
    assign data = pattern_word(seed, 32'(addr));

endmodule

// File: hw/pov_framebuffer.sv
module pov_framebuffer #(
    parameter int RAM_ADDR_WIDTH  = 32,
    parameter int RAM_BASE        = 0,
    parameter int POKER_MODE      = 9,
    parameter int BLANKING_CYCLES = 72
) (
    input  logic                            clk_33,
    input  logic                            nrst,
    input  logic [7:0]                      enc_position,
    input  logic                            enc_sync,
    output logic [RAM_ADDR_WIDTH-1:0]       ram_addr,
    input  logic [15:0]                     ram_data,
    output logic [pov_pkg::NUM_DRIVERS-1:0] data,
    output logic                            sync
);
    import pov_pkg::*;

    // Scan position and terminal flags from the timer
    scan_pos_t pos;
    logic      blank_done;
    logic      column_done;

    // Controls from the state machine
    logic blank_load;
    logic shift_en;
    logic swap;
    logic front_sel;
    logic blanking;

    // Back buffer write port from the loader
    logic                   wr_en;
    logic [BUFF_ADDR_W-1:0] wr_idx;
    pixel_u                 wr_word;

    scan_timer #(
        .POKER_MODE      (POKER_MODE),
        .BLANKING_CYCLES (BLANKING_CYCLES)
    ) i_scan_timer (
        .clk_33      (clk_33),
        .nrst        (nrst),
        .blank_load  (blank_load),
        .shift_en    (shift_en),
        .pos         (pos),
        .blank_done  (blank_done),
        .column_done (column_done)
    );

    scan_fsm #(
        .BLANKING_CYCLES (BLANKING_CYCLES)
    ) i_scan_fsm (
        .clk_33      (clk_33),
        .nrst        (nrst),
        .pos         (pos),
        .blank_done  (blank_done),
        .column_done (column_done),
        .blank_load  (blank_load),
        .shift_en    (shift_en),
        .swap        (swap),
        .front_sel   (front_sel),
        .blanking    (blanking),
        .sync        (sync)
    );

    column_loader #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .RAM_BASE       (RAM_BASE)
    ) i_column_loader (
        .clk_33       (clk_33),
        .nrst         (nrst),
        .enc_position (enc_position),
        .enc_sync     (enc_sync),
        .swap         (swap),
        .ram_addr     (ram_addr),
        .ram_data     (ram_data),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_word      (wr_word)
    );

    bit_slicer #(
        .POKER_MODE (POKER_MODE)
    ) i_bit_slicer (
        .clk_33    (clk_33),
        .nrst      (nrst),
        .front_sel (front_sel),
        .blanking  (blanking),
        .pos       (pos),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_word   (wr_word),
        .data      (data)
    );

endmodule

// File: hw/bit_slicer.sv
module bit_slicer #(
    parameter int POKER_MODE = 9
) (
    input  logic                            clk_33,
    input  logic                            nrst,
    input  logic                            front_sel,
    input  logic                            blanking,
    input  pov_pkg::scan_pos_t              pos,
    input  logic                            wr_en,
    input  logic [pov_pkg::BUFF_ADDR_W-1:0] wr_idx,
    input  pov_pkg::pixel_u                 wr_word,
    output logic [pov_pkg::NUM_DRIVERS-1:0] data
);
    import pov_pkg::*;

    // Consecutive LEDs of one driver are one row of five pairs apart
    localparam int LED_STRIDE = BUFF_SIZE / (3 * LED_PER_DRIVER);
    // Slot 8 holds the MSB of every field and anything above it is padding
    localparam bit WIDE_SLOTS = (POKER_MODE > 9);

    pixel_u buf0 [BUFF_SIZE];
    pixel_u buf1 [BUFF_SIZE];

    logic [BUFF_ADDR_W-1:0] led_offset;
    logic [2:0]             field_idx;
    logic                   slot_valid;
    logic                   in_field;
    logic [NUM_DRIVERS-1:0] data_next;

    // The loader always writes the buffer that is not on display
    always_ff @(posedge clk_33) begin
        if (wr_en) begin
            if (front_sel) begin
                buf0[wr_idx] <= wr_word;
            end else begin
                buf1[wr_idx] <= wr_word;
            end
        end
    end

    assign led_offset = BUFF_ADDR_W'(LED_STRIDE * pos.led);

    // Green has six bits and starts one slot lower than red and blue
    assign field_idx  = (pos.colour == 2'd1) ? 3'(pos.bit_slot - 4'd3) : 3'(pos.bit_slot - 4'd4);
    assign in_field   = !WIDE_SLOTS || (pos.bit_slot <= 4'd8);
    // The four lowest slots pad with zero, except green's LSB in slot 3
    assign slot_valid = in_field
                     && ((pos.bit_slot > 4'd3) || ((pos.colour == 2'd1) && (pos.bit_slot == 4'd3)));

    for (genvar d = 0; d < NUM_DRIVERS; d++) begin : g_drv
        logic [BUFF_ADDR_W-1:0] rd_idx;
        pixel_u                 word;
        logic [5:0]             field;

        assign rd_idx = DRIVER_BASE[d] + led_offset;
        assign word   = front_sel ? buf1[rd_idx] : buf0[rd_idx];

        // Five-bit fields are zero extended so one index works for all colours
        always_comb begin
            case (pos.colour)
                2'd0:    field = {1'b0, word.rgb565.red};
                2'd1:    field = word.rgb565.green;
                default: field = {1'b0, word.rgb565.blue};
            endcase
        end

        assign data_next[d] = slot_valid && field[field_idx];
    end

    // One register stage from scan position to the driver word
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            data <= '0;
        end else if (blanking) begin
            data <= '0;
        end else begin
            data <= data_next;
        end
    end

endmodule

// File: hw/column_loader.sv
module column_loader #(
    parameter int RAM_ADDR_WIDTH = 32,
    parameter int RAM_BASE       = 0
) (
    input  logic                            clk_33,
    input  logic                            nrst,
    input  logic [7:0]                      enc_position,
    input  logic                            enc_sync,
    input  logic                            swap,
    output logic [RAM_ADDR_WIDTH-1:0]       ram_addr,
    input  logic [15:0]                     ram_data,
    output logic                            wr_en,
    output logic [pov_pkg::BUFF_ADDR_W-1:0] wr_idx,
    output pov_pkg::pixel_u                 wr_word
);
    import pov_pkg::*;

    localparam int COL_W = $clog2(MULTIPLEXING);

    logic [RAM_ADDR_WIDTH-1:0] image_start;
    logic [RAM_ADDR_WIDTH-1:0] new_start;
    logic [COL_W-1:0]          column;
    logic [COL_W-1:0]          next_column;
    logic [BUFF_ADDR_W-1:0]    word_idx;
    logic                      loading;
    logic                      last_word;

    // Each encoder position selects one whole image in RAM
    assign new_start = RAM_ADDR_WIDTH'(RAM_BASE)
                     + RAM_ADDR_WIDTH'(enc_position) * RAM_ADDR_WIDTH'(IMAGE_SIZE);

    assign next_column = (column == COL_W'(MULTIPLEXING - 1)) ? '0 : column + 1'b1;
    assign last_word   = (word_idx == BUFF_ADDR_W'(BUFF_SIZE - 1));

    // Stepping the address by 8 keeps the same column of the next driver strip
    // A new image restarts at column 0 and a swap moves on to the next column
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            image_start <= RAM_ADDR_WIDTH'(RAM_BASE);
            ram_addr    <= RAM_ADDR_WIDTH'(RAM_BASE);
            column      <= '0;
            word_idx    <= '0;
            loading     <= 1'b1;
        end else if (enc_sync) begin
            image_start <= new_start;
            ram_addr    <= new_start;
            column      <= '0;
            word_idx    <= '0;
            loading     <= 1'b1;
        end else if (swap) begin
            column   <= next_column;
            ram_addr <= image_start + RAM_ADDR_WIDTH'(next_column);
            word_idx <= '0;
            loading  <= 1'b1;
        end else if (loading) begin
            ram_addr <= ram_addr + RAM_ADDR_WIDTH'(MULTIPLEXING);
            word_idx <= word_idx + 1'b1;
            // Stop after word 239 and idle until the next swap
            loading  <= !last_word;
        end
    end

    // The RAM answers in the same cycle, so the word is registered with its index
    // A restart cycle carries a stale address and writes nothing
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= loading && !enc_sync && !swap;
        end
    end

    always_ff @(posedge clk_33) begin
        wr_idx      <= word_idx;
        wr_word.raw <= ram_data;
    end

endmodule

// File: hw/scan_fsm.sv
module scan_fsm #(
    parameter int BLANKING_CYCLES = 72
) (
    input  logic               clk_33,
    input  logic               nrst,
    input  pov_pkg::scan_pos_t pos,
    input  logic               blank_done,
    input  logic               column_done,
    output logic               blank_load,
    output logic               shift_en,
    output logic               swap,
    output logic               front_sel,
    output logic               blanking,
    output logic               sync
);

    // With a single blank cycle there is no second blank cycle to carry sync
    localparam bit HAS_SECOND_BLANK = (BLANKING_CYCLES > 1);

    typedef enum logic {
        ST_BLANK,
        ST_SHIFT
    } state_t;

    state_t state;
    // High during the first cycle of every blank period
    logic   first_blank;

    assign blanking = (state == ST_BLANK);
    assign shift_en = (state == ST_SHIFT);

    // The last shift slot closes the column
    // Swapping here lets the new blank period start on the next buffer
    assign swap       = shift_en && column_done;
    assign blank_load = swap;

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            state <= ST_BLANK;
        end else begin
            case (state)
                ST_BLANK: begin
                    if (blank_done) begin
                        state <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    if (column_done) begin
                        state <= ST_BLANK;
                    end
                end
                default: begin
                    state <= ST_BLANK;
                end
            endcase
        end
    end

    // Front buffer flips once per column
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            front_sel <= 1'b0;
        end else if (swap) begin
            front_sel <= ~front_sel;
        end
    end

    // Reset counts as entering blank, so the first column also gets a sync
    // The column counter has already wrapped when the blank period starts
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            first_blank <= 1'b1;
            sync        <= 1'b0;
        end else begin
            first_blank <= swap;
            sync        <= HAS_SECOND_BLANK && blanking && first_blank && (pos.column == 3'd0);
        end
    end

endmodule

// File: hw/scan_timer.sv
module scan_timer #(
    parameter int POKER_MODE      = 9,
    parameter int BLANKING_CYCLES = 72
) (
    input  logic               clk_33,
    input  logic               nrst,
    input  logic               blank_load,
    input  logic               shift_en,
    output pov_pkg::scan_pos_t pos,
    output logic               blank_done,
    output logic               column_done
);
    import pov_pkg::*;

    // The countdown needs at least one bit even for a single blank cycle
    localparam int BLANK_W = (BLANKING_CYCLES > 1) ? $clog2(BLANKING_CYCLES) : 1;

    logic [BLANK_W-1:0] blank_cnt;
    logic               colour_last;
    logic               led_last;
    logic               slot_last;

    // Terminal counts of the nested shift counters
    assign colour_last = (pos.colour == 2'd2);
    assign led_last    = (pos.led == 4'(LED_PER_DRIVER - 1));
    assign slot_last   = (pos.bit_slot == 4'd0);

    // Blue of LED 15 in bit slot 0 is the last shift slot of a column
    assign column_done = colour_last && led_last && slot_last;
    // The count sits at zero during the final blank cycle
    assign blank_done  = (blank_cnt == '0);

    // The countdown starts loaded so the first column opens with a full blank
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            blank_cnt <= BLANK_W'(BLANKING_CYCLES - 1);
        end else if (blank_load) begin
            blank_cnt <= BLANK_W'(BLANKING_CYCLES - 1);
        end else if (blank_cnt != '0) begin
            blank_cnt <= blank_cnt - 1'b1;
        end
    end

    // Colour steps fastest, then LED, then the bit slot counts down MSB first
    // The column only moves once every slot of the column has been sent
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            pos.colour   <= '0;
            pos.led      <= '0;
            pos.bit_slot <= 4'(POKER_MODE - 1);
            pos.column   <= '0;
        end else if (shift_en) begin
            if (colour_last) begin
                pos.colour <= '0;
                if (led_last) begin
                    pos.led <= '0;
                    if (slot_last) begin
                        pos.bit_slot <= 4'(POKER_MODE - 1);
                        // Column 7 wraps back to 0 to start the next slice
                        if (pos.column == 3'(MULTIPLEXING - 1)) begin
                            pos.column <= '0;
                        end else begin
                            pos.column <= pos.column + 1'b1;
                        end
                    end else begin
                        pos.bit_slot <= pos.bit_slot - 1'b1;
                    end
                end else begin
                    pos.led <= pos.led + 1'b1;
                end
            end else begin
                pos.colour <= pos.colour + 1'b1;
            end
        end
    end

endmodule

// File: hw/pov_pkg.sv
package pov_pkg;

    // Columns shown per slice, one per multiplexing step of the drivers
    localparam int MULTIPLEXING = 8;
    // Each driver lights a strip of 16 LEDs for every column
    localparam int LED_PER_DRIVER = 16;
    localparam int NUM_DRIVERS = 30;
    // One image is 40 columns of 48 pixels in external RAM
    localparam int IMAGE_SIZE = 1920;
    // One buffer holds one column for each of the 15 driver pairs
    localparam int BUFF_SIZE = 240;
    localparam int BUFF_ADDR_W = 8;

    // RGB565 layout with red in the top bits and blue in the bottom bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // The loader stores raw RAM words and the slicer reads colour fields
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     rgb565;
    } pixel_u;

    // Current scan position, with colour 0 for red, 1 for green and 2 for blue
    typedef struct packed {
        logic [1:0] colour;
        logic [3:0] led;
        logic [3:0] bit_slot;
        logic [2:0] column;
    } scan_pos_t;

    // Drivers face each other in pairs, so 2p and 2p+1 read the same pixel
    // The pairs sit five to a row and each row spans 5 x 16 buffer words
    function automatic logic [NUM_DRIVERS-1:0][BUFF_ADDR_W-1:0] driver_base_table();
        logic [NUM_DRIVERS-1:0][BUFF_ADDR_W-1:0] tab;
        int pair;
        for (int d = 0; d < NUM_DRIVERS; d++) begin
            pair = d / 2;
            tab[d] = BUFF_ADDR_W'((pair % 5) + 5 * LED_PER_DRIVER * (pair / 5));
        end
        return tab;
    endfunction

    localparam logic [NUM_DRIVERS-1:0][BUFF_ADDR_W-1:0] DRIVER_BASE = driver_base_table();

endpackage
